// ==== sources.f ====
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_rx_egress.sv
source/uart_top.sv
verification/uart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "all tests passed" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/uart_stim.txt ====
// kind div data_bits parity stop_bits byte inv_parity zero_stop exp_data exp_parity_err exp_frame_err
// kind: 0 loopback, 1 injected frame, 2 credit burst, 3 overrun burst, f end of records
0 000a 1 0 0 a5 0 0 a5 0 0
0 000a 1 0 0 3c 0 0 3c 0 0
0 000c 1 1 0 5a 0 0 5a 0 0
0 000c 1 1 1 81 0 0 81 0 0
0 0010 1 2 0 7e 0 0 7e 0 0
0 0010 1 2 1 01 0 0 01 0 0
0 000a 0 3 0 d3 0 0 53 0 0
0 000a 0 4 1 ff 0 0 7f 0 0
0 0009 0 1 0 aa 0 0 2a 0 0
0 0008 0 2 1 c1 0 0 41 0 0
// Injected frames with a corrupted parity bit or a low stop bit
1 000a 1 1 0 96 1 0 96 1 0
1 000a 0 2 0 35 1 0 35 1 0
1 000a 1 3 1 4b 1 0 4b 1 0
1 000a 1 0 0 c3 0 1 c3 0 1
1 000c 0 1 1 22 0 1 22 0 1
1 000a 1 2 0 18 0 0 18 0 0
// Bursts count up from the byte column
2 0008 1 0 0 10 0 0 10 0 0
3 0008 1 1 0 40 0 0 40 0 0
f 0000 0 0 0 00 0 0 00 0 0

// ==== verification/uart_tb.sv ====
`timescale 1ns/10ps

module uart_tb;

    localparam int TX_DEPTH = 8;
    localparam int RX_DEPTH = 8;
    localparam int FIELDS   = 11;     // Columns in one stimulus record
    localparam int MAX_RECS = 40;
    localparam int TIMEOUT  = 20000;  // Clock cycles allowed for any single wait

    logic                       clk_i;
    logic                       rst_n_i;
    logic [uart_pkg::DIV_W-1:0] div_i;
    uart_pkg::data_bits_t       data_bits_i;
    uart_pkg::parity_t          parity_i;
    uart_pkg::stop_bits_t       stop_bits_i;
    logic                       tx_push_i;
    logic [7:0]                 tx_data_i;
    logic                       tx_credit_o;
    logic                       txd_o;
    logic                       rx_credit_i;
    logic                       rxd_i;
    logic                       rx_valid_o;
    uart_pkg::uart_rx_word_t    rx_word_o;
    logic                       rx_overrun_o;

    logic                       loop_mode;
    logic                       inj_line;
    logic [15:0]                stim_mem [512];
    logic [15:0]                rec_f [FIELDS];
    logic [31:0]                rng_state;
    uart_pkg::uart_rx_word_t    rx_q [$];
    int                         rd_idx;
    int                         pushed;
    int                         granted;
    int                         tx_pulses;
    int                         overruns;

    assign rxd_i = loop_mode ? txd_o : inj_line;  // Serial line model

    uart_top #(
        .TX_DEPTH (TX_DEPTH),
        .RX_DEPTH (RX_DEPTH)
    ) u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Falling edge sampling keeps the counts clear of the rising edge updates
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (tx_credit_o) tx_pulses++;
            if (rx_overrun_o) overruns++;
            if (rx_valid_o) begin
                if (granted == rx_q.size()) report_failure("rx_valid_o rose with no rx credit");
                rx_q.push_back(rx_word_o);
            end
        end
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input uart_pkg::uart_rx_word_t exp,
                              input uart_pkg::uart_rx_word_t act);
        if (act !== exp) begin
            report_failure($sformatf(
                "Error at %0t: %s expected %h par=%b frm=%b, actual %h par=%b frm=%b",
                $time, name, exp.data, exp.parity_err, exp.frame_err,
                act.data, act.parity_err, act.frame_err));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("Error at %0t: %s expected %b, actual %b",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("Error at %0t: %s expected %0d, actual %0d",
                                     $time, name, exp, act));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Parity bit the line carries in the configured mode
    function automatic logic parity_bit(input logic [7:0] data);
        logic odd_ones;
        odd_ones = ^data[6:0];
        if (data_bits_i == uart_pkg::DATA_EIGHT) begin
            odd_ones = odd_ones ^ data[7];
        end
        case (parity_i)
            uart_pkg::PARITY_EVEN: return odd_ones;
            uart_pkg::PARITY_ODD:  return !odd_ones;
            uart_pkg::PARITY_MARK: return 1'b1;
            default:               return 1'b0;
        endcase
    endfunction

    task automatic wait_tx_pulses(input int target, input string what);
        int cycles;
        cycles = 0;
        while (tx_pulses < target) begin
            if (cycles == TIMEOUT) report_failure({"Timeout: no tx_credit_o pulse for ", what});
            @(posedge clk_i);
            cycles++;
        end
    endtask

    task automatic wait_words(input int n);
        int cycles;
        cycles = 0;
        while (rx_q.size() < rd_idx + n) begin
            if (cycles == TIMEOUT) report_failure("Timeout: no word arrived on rx_valid_o");
            @(posedge clk_i);
            cycles++;
        end
    endtask

    task automatic wait_overrun(input int target);
        int cycles;
        cycles = 0;
        while (overruns < target) begin
            if (cycles == TIMEOUT) report_failure("Timeout: rx_overrun_o never pulsed");
            @(posedge clk_i);
            cycles++;
        end
    endtask

    task automatic push_byte(input logic [7:0] b);
        wait_tx_pulses(pushed - TX_DEPTH + 1, "a free transmit slot");  // Host needs a credit
        @(posedge clk_i);
        tx_push_i <= 1'b1;
        tx_data_i <= b;
        pushed++;
        @(posedge clk_i);
        tx_push_i <= 1'b0;
    endtask

    task automatic grant_rx_credit();
        rng_state = xorshift32(rng_state);
        repeat (rng_state[2:0]) @(posedge clk_i);
        @(posedge clk_i);
        rx_credit_i <= 1'b1;
        granted++;
        @(posedge clk_i);
        rx_credit_i <= 1'b0;
    endtask

    task automatic take_word(input uart_pkg::uart_rx_word_t exp);
        wait_words(1);
        check_word("rx_word_o", exp, rx_q[rd_idx]);
        rd_idx++;
    endtask

    task automatic drive_bit(input logic b);
        inj_line <= b;
        repeat (div_i) @(posedge clk_i);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic inv_par, input logic zero_stop);
        logic [7:0] shreg;
        int         nbits;
        shreg = data;
        nbits = (data_bits_i == uart_pkg::DATA_EIGHT) ? 8 : 7;
        @(posedge clk_i);
        drive_bit(1'b0);
        repeat (nbits) begin
            drive_bit(shreg[0]);  // LSB first
            shreg = shreg >> 1;
        end
        if (parity_i != uart_pkg::PARITY_NONE) drive_bit(parity_bit(data) ^ inv_par);
        drive_bit(!zero_stop);
        if (stop_bits_i == uart_pkg::STOP_TWO) drive_bit(1'b1);
        drive_bit(1'b1);
    endtask

    task automatic load_record(input int r);
        for (int c = 0; c < FIELDS; c++) begin
            rec_f[4'(c)] = stim_mem[9'(r * FIELDS + c)];
        end
    endtask

    // Line settings only change once both directions have gone quiet
    task automatic apply_config();
        repeat (3 * int'(div_i)) @(posedge clk_i);
        div_i       <= rec_f[1];
        data_bits_i <= uart_pkg::data_bits_t'(rec_f[2][0]);
        parity_i    <= uart_pkg::parity_t'(rec_f[3][2:0]);
        stop_bits_i <= uart_pkg::stop_bits_t'(rec_f[4][0]);
        loop_mode   <= (rec_f[0][3:0] != 4'h1);
        repeat (2) @(posedge clk_i);
    endtask

    task automatic run_burst(input logic [7:0] first, input uart_pkg::uart_rx_word_t exp,
                             input logic overrun);
        int                      n;
        int                      tx_base;
        int                      ov_base;
        uart_pkg::uart_rx_word_t e;
        n       = overrun ? RX_DEPTH + 1 : TX_DEPTH;
        tx_base = tx_pulses;
        ov_base = overruns;
        e       = exp;
        for (int i = 0; i < n; i++) push_byte(first + 8'(i));
        if (overrun) begin
            wait_overrun(ov_base + 1);
            n = RX_DEPTH;
        end else begin
            wait_tx_pulses(tx_base + n, "the burst");
            repeat (14 * int'(div_i)) @(posedge clk_i);  // Last frame reaches the receive FIFO
            check_count("rx_valid_o words without credit", 0, rx_q.size() - rd_idx);
        end
        for (int i = 0; i < n; i++) grant_rx_credit();
        for (int i = 0; i < n; i++) begin
            e.data = exp.data + 8'(i);
            take_word(e);
        end
        if (overrun) check_count("rx_overrun_o pulses", 1, overruns - ov_base);
        else check_count("tx_credit_o pulses", TX_DEPTH, tx_pulses - tx_base);
    endtask

    initial begin
        int                      rec;
        uart_pkg::uart_rx_word_t exp_w;

        rst_n_i     <= 1'b0;
        div_i       <= 16'd10;
        data_bits_i <= uart_pkg::DATA_EIGHT;
        parity_i    <= uart_pkg::PARITY_NONE;
        stop_bits_i <= uart_pkg::STOP_ONE;
        tx_push_i   <= 1'b0;
        tx_data_i   <= 8'h00;
        rx_credit_i <= 1'b0;
        loop_mode   <= 1'b0;
        inj_line    <= 1'b1;
        rng_state   = 32'd6950;
        $readmemh("verification/uart_stim.txt", stim_mem);
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        @(negedge clk_i);
        check_bit("txd_o", 1'b1, txd_o);
        check_bit("rx_valid_o", 1'b0, rx_valid_o);
        check_bit("tx_credit_o", 1'b0, tx_credit_o);
        check_bit("rx_overrun_o", 1'b0, rx_overrun_o);

        rec = 0;
        load_record(rec);
        while (rec < MAX_RECS && rec_f[0][3:0] != 4'hf) begin
            exp_w.data       = rec_f[8][7:0];
            exp_w.parity_err = rec_f[9][0];
            exp_w.frame_err  = rec_f[10][0];
            apply_config();
            case (rec_f[0][3:0])
                4'h0: begin
                    push_byte(rec_f[5][7:0]);
                    grant_rx_credit();
                    take_word(exp_w);
                end
                4'h1: begin
                    send_frame(rec_f[5][7:0], rec_f[6][0], rec_f[7][0]);
                    grant_rx_credit();
                    take_word(exp_w);
                end
                4'h2:    run_burst(rec_f[5][7:0], exp_w, 1'b0);
                4'h3:    run_burst(rec_f[5][7:0], exp_w, 1'b1);
                default: report_failure("Unknown record kind in the stimulus file");
            endcase
            rec++;
            load_record(rec);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== source/uart_top.sv ====
`timescale 1ns/10ps

module uart_top #(
    parameter int TX_DEPTH = 8,
    parameter int RX_DEPTH = 8
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic [uart_pkg::DIV_W-1:0] div_i,
    input  uart_pkg::data_bits_t       data_bits_i,
    input  uart_pkg::parity_t          parity_i,
    input  uart_pkg::stop_bits_t       stop_bits_i,
    input  logic                       tx_push_i,
    input  logic [7:0]                 tx_data_i,
    output logic                       tx_credit_o,
    output logic                       txd_o,
    input  logic                       rx_credit_i,
    input  logic                       rxd_i,
    output logic                       rx_valid_o,
    output uart_pkg::uart_rx_word_t    rx_word_o,
    output logic                       rx_overrun_o
);

    logic [7:0]              tx_fifo_data_w;
    logic                    tx_fifo_empty_w;
    logic                    rx_word_valid_w;
    uart_pkg::uart_rx_word_t rx_word_w;

    // Host credits bound the occupancy, so the full flag has no consumer
    uart_fifo #(
        .DEPTH     (TX_DEPTH),
        .payload_t (logic [7:0])
    ) u_tx_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (tx_push_i),
        .push_data_i (tx_data_i),
        .pop_i       (tx_credit_o),
        .pop_data_o  (tx_fifo_data_w),
        .empty_o     (tx_fifo_empty_w),
        .full_o      ()
    );

    // Every pop frees a slot and returns one credit to the host
    uart_tx u_tx (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .div_i        (div_i),
        .data_bits_i  (data_bits_i),
        .parity_i     (parity_i),
        .stop_bits_i  (stop_bits_i),
        .fifo_data_i  (tx_fifo_data_w),
        .fifo_empty_i (tx_fifo_empty_w),
        .fifo_pop_o   (tx_credit_o),
        .txd_o        (txd_o)
    );

    uart_rx u_rx (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .rxd_i        (rxd_i),
        .div_i        (div_i),
        .data_bits_i  (data_bits_i),
        .parity_i     (parity_i),
        .stop_bits_i  (stop_bits_i),
        .word_valid_o (rx_word_valid_w),
        .word_o       (rx_word_w)
    );

    uart_rx_egress #(
        .DEPTH (RX_DEPTH)
    ) u_rx_egress (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .word_valid_i (rx_word_valid_w),
        .word_i       (rx_word_w),
        .rx_credit_i  (rx_credit_i),
        .rx_valid_o   (rx_valid_o),
        .rx_word_o    (rx_word_o),
        .rx_overrun_o (rx_overrun_o)
    );

endmodule

// ==== source/uart_rx_egress.sv ====
`timescale 1ns/10ps

module uart_rx_egress #(
    parameter int DEPTH = 8
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    word_valid_i,
    input  uart_pkg::uart_rx_word_t word_i,
    input  logic                    rx_credit_i,
    output logic                    rx_valid_o,
    output uart_pkg::uart_rx_word_t rx_word_o,
    output logic                    rx_overrun_o
);

    localparam int CREDIT_W = 8;

    uart_pkg::uart_rx_word_t fifo_data_w;
    logic                    fifo_empty_w;
    logic                    fifo_full_w;
    logic                    deliver_w;
    logic [CREDIT_W-1:0]     credit_r;

    uart_fifo #(
        .DEPTH     (DEPTH),
        .payload_t (uart_pkg::uart_rx_word_t)
    ) u_rx_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (word_valid_i),
        .push_data_i (word_i),
        .pop_i       (deliver_w),
        .pop_data_o  (fifo_data_w),
        .empty_o     (fifo_empty_w),
        .full_o      (fifo_full_w)
    );

    // A word leaves only while the host has a free slot
    assign deliver_w = !fifo_empty_w && (credit_r != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credit_r     <= '0;
            rx_valid_o   <= 1'b0;
            rx_overrun_o <= 1'b0;
        end else begin
            case ({rx_credit_i, deliver_w})
                2'b10:   credit_r <= credit_r + 1'b1;
                2'b01:   credit_r <= credit_r - 1'b1;
                default: credit_r <= credit_r;  // Grant and delivery cancel out
            endcase
            rx_valid_o   <= deliver_w;
            rx_overrun_o <= word_valid_i && fifo_full_w;
        end
    end

    always_ff @(posedge clk_i) begin
        rx_word_o <= fifo_data_w;
    end

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       rxd_i,
    input  logic [uart_pkg::DIV_W-1:0] div_i,
    input  uart_pkg::data_bits_t       data_bits_i,
    input  uart_pkg::parity_t          parity_i,
    input  uart_pkg::stop_bits_t       stop_bits_i,
    output logic                       word_valid_o,
    output uart_pkg::uart_rx_word_t    word_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_PARITY,
        ST_STOP
    } state_t;

    state_t                     state_r;
    logic                       rxd_meta_r;
    logic                       rxd_sync_r;
    logic                       rxd_prev_r;
    logic [uart_pkg::DIV_W-1:0] timer_r;
    logic                       tick_w;
    logic [2:0]                 bit_cnt_r;
    logic [7:0]                 data_r;
    logic                       parity_err_r;
    logic                       last_bit_w;
    logic                       parity_exp_w;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rxd_meta_r <= 1'b1;
            rxd_sync_r <= 1'b1;
            rxd_prev_r <= 1'b1;
        end else begin
            rxd_meta_r <= rxd_i;
            rxd_sync_r <= rxd_meta_r;
            rxd_prev_r <= rxd_sync_r;  // Edge detect on the synchronized line
        end
    end

    assign tick_w = (timer_r == '0);

    // Half a bit while idle so the first tick lands mid start bit
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            timer_r <= '0;
        end else if (state_r == ST_IDLE) begin
            timer_r <= (div_i >> 1) - 1'b1;
        end else if (tick_w) begin
            timer_r <= div_i - 1'b1;
        end else begin
            timer_r <= timer_r - 1'b1;
        end
    end

    assign last_bit_w = (bit_cnt_r == ((data_bits_i == uart_pkg::DATA_EIGHT) ? 3'd7 : 3'd6));

    // The second stop bit is never sampled, the machine is already back in idle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_r      <= ST_IDLE;
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= 1'b0;
            case (state_r)
                ST_IDLE:   if (rxd_prev_r && !rxd_sync_r) state_r <= ST_START;
                ST_START:  if (tick_w) state_r <= rxd_sync_r ? ST_IDLE : ST_DATA;  // Glitch rejection
                ST_DATA: begin
                    if (tick_w && last_bit_w) begin
                        state_r <= (parity_i == uart_pkg::PARITY_NONE) ? ST_STOP : ST_PARITY;
                    end
                end
                ST_PARITY: if (tick_w) state_r <= ST_STOP;
                ST_STOP: begin
                    if (tick_w) begin
                        state_r      <= ST_IDLE;
                        word_valid_o <= 1'b1;
                    end
                end
                default:   state_r <= ST_IDLE;
            endcase
        end
    end

    // Bit 7 stays zero in seven-bit mode, so the reduction covers the right bits
    always_comb begin
        case (parity_i)
            uart_pkg::PARITY_EVEN: parity_exp_w = ^data_r;
            uart_pkg::PARITY_ODD:  parity_exp_w = ~^data_r;
            uart_pkg::PARITY_MARK: parity_exp_w = 1'b1;
            default:               parity_exp_w = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (state_r == ST_IDLE) begin
            bit_cnt_r    <= '0;
            data_r       <= '0;
            parity_err_r <= 1'b0;
        end else if (tick_w) begin
            case (state_r)
                ST_DATA: begin
                    data_r[bit_cnt_r] <= rxd_sync_r;  // LSB first
                    bit_cnt_r         <= bit_cnt_r + 3'd1;
                end
                ST_PARITY: parity_err_r <= (rxd_sync_r != parity_exp_w);
                ST_STOP: begin
                    word_o.data       <= data_r;
                    word_o.parity_err <= parity_err_r;
                    word_o.frame_err  <= !rxd_sync_r;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic [uart_pkg::DIV_W-1:0] div_i,
    input  uart_pkg::data_bits_t       data_bits_i,
    input  uart_pkg::parity_t          parity_i,
    input  uart_pkg::stop_bits_t       stop_bits_i,
    input  logic [7:0]                 fifo_data_i,
    input  logic                       fifo_empty_i,
    output logic                       fifo_pop_o,
    output logic                       txd_o
);

    logic [uart_pkg::DIV_W-1:0] timer_r;
    logic                       tick_w;
    logic [11:0]                frame_r;
    logic [11:0]                frame_w;
    logic                       txd_r;
    logic                       load_w;
    logic                       data_xor_w;
    logic                       parity_w;
    logic [3:0]                 pos_w;

    // Free-running bit timer, one tick every div_i cycles
    assign tick_w = (timer_r == '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            timer_r <= '0;
        end else if (tick_w) begin
            timer_r <= div_i - 1'b1;
        end else begin
            timer_r <= timer_r - 1'b1;
        end
    end

    // The frame register reads zero once the last stop bit is on the line
    assign load_w     = (frame_r == '0) && !fifo_empty_i;
    assign fifo_pop_o = load_w;
    assign txd_o      = txd_r;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            frame_r <= '0;
            txd_r   <= 1'b1;
        end else begin
            if (load_w) begin
                frame_r <= frame_w;
            end else if (tick_w) begin
                frame_r <= {1'b0, frame_r[11:1]};
            end
            if (tick_w) begin
                txd_r <= (frame_r == '0) ? 1'b1 : frame_r[0];  // Idle high between frames
            end
        end
    end

    always_comb begin
        data_xor_w = ^fifo_data_i[6:0];
        if (data_bits_i == uart_pkg::DATA_EIGHT) begin
            data_xor_w = data_xor_w ^ fifo_data_i[7];
        end
    end

    always_comb begin
        case (parity_i)
            uart_pkg::PARITY_EVEN: parity_w = data_xor_w;   // Total count of ones stays even
            uart_pkg::PARITY_ODD:  parity_w = !data_xor_w;
            uart_pkg::PARITY_MARK: parity_w = 1'b1;
            default:               parity_w = 1'b0;
        endcase
    end

    // Frame layout from bit 0 upward: start, data, optional parity, stop bits.
    // Unused upper bits stay zero so the register empties after the last stop bit.
    always_comb begin
        frame_w      = '0;
        frame_w[7:1] = fifo_data_i[6:0];
        pos_w        = 4'd8;
        if (data_bits_i == uart_pkg::DATA_EIGHT) begin
            frame_w[8] = fifo_data_i[7];
            pos_w      = 4'd9;
        end
        if (parity_i != uart_pkg::PARITY_NONE) begin
            frame_w[pos_w] = parity_w;
            pos_w          = pos_w + 4'd1;
        end
        frame_w[pos_w] = 1'b1;
        if (stop_bits_i == uart_pkg::STOP_TWO) begin
            frame_w[pos_w + 4'd1] = 1'b1;
        end
    end

endmodule

// ==== source/uart_fifo.sv ====
`timescale 1ns/10ps

module uart_fifo #(
    parameter int  DEPTH     = 8,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t pop_data_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem_r [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_r;
    logic [PTR_W-1:0]   rd_ptr_r;
    logic [CNT_W-1:0]   count_r;
    logic               do_push_w;
    logic               do_pop_w;

    assign empty_o   = (count_r == '0);
    assign full_o    = (count_r == CNT_W'(DEPTH));
    assign do_push_w = push_i && !full_o;  // Pushing into a full FIFO is ignored
    assign do_pop_w  = pop_i && !empty_o;

    // Show-ahead output
    assign pop_data_o = mem_r[rd_ptr_r];

    always_ff @(posedge clk_i) begin
        if (do_push_w) begin
            mem_r[wr_ptr_r] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (do_push_w) begin
                wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
            end
            if (do_pop_w) begin
                rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
            end
            case ({do_push_w, do_pop_w})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
        end
    end

endmodule

// ==== source/uart_pkg.sv ====
package uart_pkg;

    // Cycles-per-bit divisor width
    localparam int DIV_W = 16;

    typedef enum logic {
        DATA_SEVEN = 1'b0,
        DATA_EIGHT = 1'b1
    } data_bits_t;

    typedef enum logic [2:0] {
        PARITY_NONE  = 3'd0,
        PARITY_EVEN  = 3'd1,
        PARITY_ODD   = 3'd2,
        PARITY_MARK  = 3'd3,
        PARITY_SPACE = 3'd4
    } parity_t;

    typedef enum logic {
        STOP_ONE = 1'b0,
        STOP_TWO = 1'b1
    } stop_bits_t;

    // One received character as it is handed to the host.
    // In seven-bit mode data[7] is always zero.
    typedef struct packed {
        logic [7:0] data;
        logic       parity_err;  // Parity bit disagreed with the configured rule
        logic       frame_err;   // First stop bit sampled low
    } uart_rx_word_t;

endpackage
